// File: cpuCore.f
+incdir+rtl
rtl/cpuTypes_pkg.sv
rtl/insnDecode.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/cpuCore.sv
verif/tbClock.sv
verif/tbChecker.sv
verif/tbTop.sv

// File: Makefile
TOP = tbTop

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f cpuCore.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -x "TB PASSED" > /dev/null

clean:
	rm -rf obj_dir

// File: verif/tbTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCore_defs.svh"

module tbTop;

    localparam int PROG_LEN  = 200;
    localparam int HALT_WAIT = 5000;     // Cycles allowed for the whole program

    logic               clk;
    logic               reset_n;
    logic [`WORD_W-1:0] instrAddr;
    logic [`WORD_W-1:0] instrData;
    logic               dataValid;
    logic               dataWrite;
    logic [`WORD_W-1:0] dataAddr;
    logic [`WORD_W-1:0] dataWdata;
    logic               dataReady;
    logic [`WORD_W-1:0] dataRdata;
    logic               halt;

    logic [`WORD_W-1:0] prog [PROG_LEN];
    logic [`WORD_W-1:0] dmem [logic [`WORD_W-1:0]];
    logic [`WORD_W-1:0] progIdx;
    integer             seed;
    int                 waitLeft;
    int                 cycles;
    int                 errCount;
    int                 insnCount;
    int                 xferCount;
    logic               timedOut;

    function automatic logic [`WORD_W-1:0] fillWord(input logic [`WORD_W-1:0] addr);
        return {addr[7:0], addr[31:8]} ^ 32'h6C3A_91E5;
    endfunction

    assign progIdx   = instrAddr - `RESET_VECTOR;
    assign instrData = (progIdx < PROG_LEN) ? prog[progIdx[7:0]] : '1;  // Outside reads illegal

    initial begin
        logic [`WORD_W-1:0] word;
        int                 kind;
        logic               isJump;
        seed      = 32'h1281;
        dataReady = 1'b0;
        dataRdata = '0;
        waitLeft  = 0;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            word     = $random(seed);
            word[31] = 1'b0;                 // Keeps the word legal
            kind     = $unsigned($random(seed)) % 8;
            isJump   = (kind == 0) && (i < PROG_LEN - 10);
            if (isJump)
                word = {8'h4F, 8'h0F, 13'h0, word[2:0]};   // r15 = pc + 1 + offset
            else if (kind == 1)
                word = {2'b01, word[29], 1'b1, word[27:24], 20'h0, word[3:0]};  // Small address
            if (!isJump && !word[29] && word[27:24] == 4'hF)
                word[27:24] = 4'hE;          // No other writes to r15
            prog[i] = word;
        end
        prog[PROG_LEN-1] = '1;

        cycles = 0;
        while (halt !== 1'b1 && cycles < HALT_WAIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        timedOut = (halt !== 1'b1);
        if (timedOut)
            $display("Timeout: halt not raised within %0d cycles", HALT_WAIT);
        else
            repeat (5) @(posedge clk);       // instrAddr must stay put while halted
        $display("Errors %0d, instructions %0d, data transfers %0d",
                 errCount, insnCount, xferCount);
        if (errCount == 0 && !timedOut)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Data memory with 0 to 3 cycles of back-pressure
    always @(posedge clk) begin
        #1;
        if (dataReady) begin
            dataReady = 1'b0;                // Transfer done on this edge
        end else if (dataValid) begin
            if (waitLeft > 0) begin
                waitLeft--;
            end else begin
                dataReady = 1'b1;
                if (dataWrite)
                    dmem[dataAddr] = dataWdata;
                else
                    dataRdata = dmem.exists(dataAddr) ? dmem[dataAddr] : fillWord(dataAddr);
                waitLeft = $unsigned($random(seed)) % 4;
            end
        end
    end

    tbClock u_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    cpuCore u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataValid (dataValid),
        .dataWrite (dataWrite),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataReady (dataReady),
        .dataRdata (dataRdata),
        .halt      (halt)
    );

    tbChecker #(.PROG_LEN(PROG_LEN)) u_checker (
        .clk       (clk),
        .reset_n   (reset_n),
        .prog      (prog),
        .instrAddr (instrAddr),
        .dataValid (dataValid),
        .dataWrite (dataWrite),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataReady (dataReady),
        .dataRdata (dataRdata),
        .halt      (halt),
        .errCount  (errCount),
        .insnCount (insnCount),
        .xferCount (xferCount)
    );

endmodule

`default_nettype wire

// File: verif/tbChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCore_defs.svh"

module tbChecker
    import cpuTypes_pkg::*;
#(
    parameter int PROG_LEN = 200
) (
    input  logic               clk,
    input  logic               reset_n,
    input  logic [`WORD_W-1:0] prog [PROG_LEN],
    input  logic [`WORD_W-1:0] instrAddr,
    input  logic               dataValid,
    input  logic               dataWrite,
    input  logic [`WORD_W-1:0] dataAddr,
    input  logic [`WORD_W-1:0] dataWdata,
    input  logic               dataReady,
    input  logic [`WORD_W-1:0] dataRdata,
    input  logic               halt,
    output int                 errCount,
    output int                 insnCount,
    output int                 xferCount
);

    logic [`WORD_W-1:0] regs [16];
    logic [`WORD_W-1:0] mem [logic [`WORD_W-1:0]];
    logic [`WORD_W-1:0] mpc;             // Address of the modelled instruction
    logic [`WORD_W-1:0] nextPc;
    logic [`WORD_W-1:0] expAddr;
    logic [`WORD_W-1:0] expWdata;
    logic [`WORD_W-1:0] expLoad;
    logic               expHalt;
    logic               expMem;
    logic               expWrite;
    logic               started;
    int                 cycles;
    int                 memCycles;
    int                 xfers;

    function automatic logic [`WORD_W-1:0] fillWord(input logic [`WORD_W-1:0] addr);
        return {addr[7:0], addr[31:8]} ^ 32'h6C3A_91E5;
    endfunction

    function automatic logic [`WORD_W-1:0] readModel(input logic [3:0] idx);
        if (idx == 4'h0)
            return '0;
        else if (idx == 4'hF)
            return mpc + 1;
        else
            return regs[idx];
    endfunction

    function automatic logic [`WORD_W-1:0] modelRhs(input aluOp_t op,
            input logic [`WORD_W-1:0] x, input logic [`WORD_W-1:0] y,
            input logic [`IMM_W-1:0] imm, input logic immType);
        logic [`WORD_W-1:0] ext;
        logic [`WORD_W-1:0] o;
        logic [`WORD_W-1:0] res;
        ext = {{(`WORD_W-`IMM_W){imm[`IMM_W-1]}}, imm};
        o   = immType ? ext : y;
        case (op)
            OP_OR:   res = x | o;
            OP_AND:  res = x & o;
            OP_ADD:  res = x + o;
            OP_MUL:  res = x * o;
            OP_SHL:  res = x << o[4:0];
            OP_LT:   res = ($signed(x) < $signed(o)) ? '1 : '0;
            OP_EQ:   res = (x == o) ? '1 : '0;
            OP_GT:   res = ($signed(x) > $signed(o)) ? '1 : '0;
            OP_ANDN: res = x & ~o;
            OP_XOR:  res = x ^ o;
            OP_SUB:  res = x - o;
            OP_XNOR: res = ~(x ^ o);
            OP_SHR:  res = x >> o[4:0];
            OP_NE:   res = (x != o) ? '1 : '0;
            default: res = '0;               // Both reserved codes
        endcase
        return res + (immType ? y : ext);
    endfunction

    task automatic expectEq(input string name, input logic [`WORD_W-1:0] expected,
            input logic [`WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %08h actual %08h", $time, name, expected, actual);
            errCount++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("%0t: %s", $time, msg);
        errCount++;
    endtask

    // Runs one whole instruction in the model
    task automatic beginInsn();
        logic [`WORD_W-1:0] word;
        logic [`WORD_W-1:0] idx;
        logic [`WORD_W-1:0] z;
        logic [`WORD_W-1:0] r;
        idx       = mpc - `RESET_VECTOR;
        word      = (idx < PROG_LEN) ? prog[idx[7:0]] : '1;
        insnCount++;
        cycles    = 1;
        memCycles = 0;
        xfers     = 0;
        expHalt   = &word;
        expMem    = !expHalt && (word[29] || word[28]);
        expWrite  = word[29];
        nextPc    = expHalt ? mpc : mpc + 1;
        if (expHalt)
            return;
        z = readModel(word[27:24]);
        r = modelRhs(aluOp_t'(word[15:12]), readModel(word[23:20]), readModel(word[19:16]),
                     word[11:0], word[30]);
        expAddr  = word[28] ? r : z;
        expWdata = word[28] ? z : r;
        expLoad  = mem.exists(r) ? mem[r] : fillWord(r);
        if (expWrite) begin
            mem[expAddr] = expWdata;
        end else begin
            if (word[28])
                r = expLoad;
            if (word[27:24] == 4'hF)
                nextPc = r;                  // Jump through r15
            else if (word[27:24] != 4'h0)
                regs[word[27:24]] = r;
        end
    endtask

    task automatic endInsn();
        expectEq("instrAddr", nextPc, instrAddr);
        if (xfers != (expMem ? 1 : 0))
            reportProblem($sformatf("%0d data transfers for instruction at %08h", xfers, mpc));
        if (cycles != 3 + memCycles)
            reportProblem($sformatf("instruction at %08h took %0d cycles", mpc, cycles));
    endtask

    always @(negedge clk) begin
        if (!reset_n) begin
            started   = 1'b0;
            errCount  = 0;
            insnCount = 0;
            xferCount = 0;
            for (int i = 0; i < 16; i++)
                regs[i] = '0;
        end else begin
            if (!started) begin
                started = 1'b1;
                expectEq("instrAddr", `RESET_VECTOR, instrAddr);
                mpc = `RESET_VECTOR;
                beginInsn();
            end else if (instrAddr != mpc) begin
                endInsn();
                mpc = instrAddr;
                beginInsn();
            end else begin
                cycles++;
            end
            expectEq("halt", expHalt && cycles >= 3, halt);
            expectEq("dataValid", expMem && cycles >= 3 && xfers == 0, dataValid);
            if (dataValid && expMem) begin
                memCycles++;
                expectEq("dataWrite", expWrite, dataWrite);
                expectEq("dataAddr", expAddr, dataAddr);
                if (expWrite)
                    expectEq("dataWdata", expWdata, dataWdata);
                if (dataReady) begin
                    xfers++;                 // Transfer on the coming edge
                    xferCount++;
                    if (!expWrite)
                        expectEq("dataRdata", expLoad, dataRdata);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;          // 100 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCore_defs.svh"

module cpuCore
    import cpuTypes_pkg::*;
(
    input  wire                clk,
    input  wire                reset_n,
    output logic [`WORD_W-1:0] instrAddr,
    input  wire  [`WORD_W-1:0] instrData,
    output logic               dataValid,
    output logic               dataWrite,
    output logic [`WORD_W-1:0] dataAddr,
    output logic [`WORD_W-1:0] dataWdata,
    input  wire                dataReady,
    input  wire  [`WORD_W-1:0] dataRdata,
    output logic               halt
);

    seqState_t          state;
    logic [`WORD_W-1:0] insnReg;     // Instruction held for the whole sequence
    logic [`WORD_W-1:0] loadData;

    logic [3:0]         idxZ;
    logic [3:0]         idxX;
    logic [3:0]         idxY;
    logic [`IMM_W-1:0]  imm;
    aluOp_t             op;
    logic               immType;
    logic               storing;
    logic               derefRight;
    logic               illegal;

    logic [`WORD_W-1:0] valueX;
    logic [`WORD_W-1:0] valueY;
    logic [`WORD_W-1:0] valueZ;
    logic [`WORD_W-1:0] rhs;
    logic [`WORD_W-1:0] writeData;

    logic memAccess;
    logic loading;
    logic jumping;
    logic writeEn;
    logic handshake;

    assign memAccess = storing | derefRight;
    assign loading   = !storing && derefRight;
    assign jumping   = !storing && (&idxZ);       // Write to register 15
    assign writeEn   = (state == WRITE) && !storing;
    assign writeData = loading ? loadData : rhs;

    // Request fields come from registered values, so they hold while waiting
    assign dataValid = (state == MEM);
    assign dataWrite = storing;
    assign dataAddr  = derefRight ? rhs : valueZ;
    assign dataWdata = derefRight ? valueZ : rhs;
    assign handshake = dataValid && dataReady;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= FETCH;
            instrAddr <= `RESET_VECTOR;
            halt      <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!halt)
                        state <= EXEC;            // Parked here once halted
                end
                EXEC: begin
                    if (illegal) begin
                        halt  <= 1'b1;
                        state <= FETCH;
                    end else if (memAccess) begin
                        state <= MEM;
                    end else begin
                        state <= WRITE;
                    end
                end
                MEM: begin
                    if (handshake)
                        state <= WRITE;           // Stall under back-pressure
                end
                WRITE: begin
                    instrAddr <= jumping ? writeData : instrAddr + 1'b1;
                    state     <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && !halt)
            insnReg <= instrData;
        if (handshake && loading)
            loadData <= dataRdata;
    end

    insnDecode uDecode (
        .insn       (insnReg),
        .idxZ       (idxZ),
        .idxX       (idxX),
        .idxY       (idxY),
        .imm        (imm),
        .op         (op),
        .immType    (immType),
        .storing    (storing),
        .derefRight (derefRight),
        .illegal    (illegal)
    );

    regFile uRegs (
        .clk       (clk),
        .reset_n   (reset_n),
        .idxX      (idxX),
        .idxY      (idxY),
        .idxZ      (idxZ),
        .pc        (instrAddr),
        .writeEn   (writeEn),
        .writeData (writeData),
        .valueX    (valueX),
        .valueY    (valueY),
        .valueZ    (valueZ)
    );

    execUnit uExec (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (state == EXEC),
        .immType (immType),
        .op      (op),
        .valueX  (valueX),
        .valueY  (valueY),
        .imm     (imm),
        .rhs     (rhs)
    );

    // Request must not change until the memory takes it
    requestStable: assert property (
        @(posedge clk) disable iff (!reset_n)
        dataValid && !dataReady |=> dataValid && $stable(dataWrite)
            && $stable(dataAddr) && $stable(dataWdata)
    ) else $error("data request changed before dataReady");

endmodule

`default_nettype wire

// File: rtl/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCore_defs.svh"

module execUnit
    import cpuTypes_pkg::*;
(
    input  wire                clk,
    input  wire                reset_n,
    input  wire                en,
    input  wire                immType,
    input  wire aluOp_t        op,
    input  wire  [`WORD_W-1:0] valueX,
    input  wire  [`WORD_W-1:0] valueY,
    input  wire  [`IMM_W-1:0]  imm,
    output logic [`WORD_W-1:0] rhs
);

    logic signed [`WORD_W-1:0] immExt;
    logic signed [`WORD_W-1:0] operandX;
    logic signed [`WORD_W-1:0] operandO;
    logic        [`WORD_W-1:0] addend;
    logic        [`WORD_W-1:0] opResult;
    logic        [4:0]         shAmt;

    assign immExt   = {{(`WORD_W-`IMM_W){imm[`IMM_W-1]}}, imm};
    assign operandX = valueX;
    assign operandO = immType ? immExt : valueY;
    assign addend   = immType ? valueY : immExt;   // The other operand is added on top
    assign shAmt    = operandO[4:0];               // Shift by low five bits only

    always_comb begin
        case (op)
            OP_OR:   opResult = operandX | operandO;
            OP_AND:  opResult = operandX & operandO;
            OP_ADD:  opResult = operandX + operandO;
            OP_MUL:  opResult = operandX * operandO;
            OP_SHL:  opResult = operandX << shAmt;
            OP_LT:   opResult = {`WORD_W{operandX < operandO}};   // All ones when true
            OP_EQ:   opResult = {`WORD_W{operandX == operandO}};
            OP_GT:   opResult = {`WORD_W{operandX > operandO}};
            OP_ANDN: opResult = operandX & ~operandO;
            OP_XOR:  opResult = operandX ^ operandO;
            OP_SUB:  opResult = operandX - operandO;
            OP_XNOR: opResult = operandX ^ ~operandO;
            OP_SHR:  opResult = valueX >> shAmt;              // Logical, unsigned source
            OP_NE:   opResult = {`WORD_W{operandX != operandO}};
            default: opResult = '0;                           // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rhs <= '0;
        end else if (en) begin
            rhs <= opResult + addend;
        end
    end

    opKnown: assert property (
        @(posedge clk) disable iff (!reset_n)
        en |-> !$isunknown(op)
    ) else $error("execUnit enabled with unknown operation");

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCore_defs.svh"

module regFile (
    input  wire                clk,
    input  wire                reset_n,
    input  wire  [3:0]         idxX,
    input  wire  [3:0]         idxY,
    input  wire  [3:0]         idxZ,
    input  wire  [`WORD_W-1:0] pc,
    input  wire                writeEn,
    input  wire  [`WORD_W-1:0] writeData,
    output logic [`WORD_W-1:0] valueX,
    output logic [`WORD_W-1:0] valueY,
    output logic [`WORD_W-1:0] valueZ
);

    localparam int IDX_W  = $clog2(`REG_COUNT);
    localparam int PC_IDX = `REG_COUNT - 1;

    logic [`WORD_W-1:0] regs [1:`REG_COUNT-2];  // General registers only

    // Zero and PC views sit outside the array
    function automatic logic [`WORD_W-1:0] readReg(input logic [IDX_W-1:0] idx);
        if (idx == '0)
            return '0;
        else if (idx == IDX_W'(PC_IDX))
            return pc + 1'b1;                    // PC view reads the next address
        else
            return regs[idx];
    endfunction

    assign valueX = readReg(idxX);
    assign valueY = readReg(idxY);
    assign valueZ = readReg(idxZ);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i <= `REG_COUNT - 2; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && idxZ != '0 && idxZ != IDX_W'(PC_IDX)) begin
            regs[idxZ] <= writeData;             // Jumps are handled by the core
        end
    end

    writeDataKnown: assert property (
        @(posedge clk) disable iff (!reset_n)
        writeEn |-> !$isunknown(writeData)
    ) else $error("regFile write with unknown data");

endmodule

`default_nettype wire

// File: rtl/insnDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpuCore_defs.svh"

module insnDecode
    import cpuTypes_pkg::*;
(
    input  wire  [`WORD_W-1:0] insn,
    output logic [3:0]         idxZ,
    output logic [3:0]         idxX,
    output logic [3:0]         idxY,
    output logic [`IMM_W-1:0]  imm,
    output aluOp_t             op,
    output logic               immType,
    output logic               storing,
    output logic               derefRight,
    output logic               illegal
);

    assign immType    = insn[30];            // O comes from the immediate
    assign storing    = insn[29];
    assign derefRight = insn[28];            // Memory address is the right-hand side
    assign idxZ       = insn[27:24];
    assign idxX       = insn[23:20];
    assign idxY       = insn[19:16];
    assign op         = aluOp_t'(insn[15:12]);
    assign imm        = insn[`IMM_W-1:0];

    assign illegal    = &insn;               // All ones halts the core

endmodule

`default_nettype wire

// File: rtl/cpuTypes_pkg.sv
`default_nettype none

package cpuTypes_pkg;

    // Operation field of the instruction word
    typedef enum logic [3:0] {
        OP_OR    = 4'h0,  // X | O
        OP_AND   = 4'h1,  // X & O
        OP_ADD   = 4'h2,  // X + O
        OP_MUL   = 4'h3,  // X * O
        OP_RSV4  = 4'h4,  // Reserved
        OP_SHL   = 4'h5,  // X << O
        OP_LT    = 4'h6,  // Signed X < O
        OP_EQ    = 4'h7,  // X == O
        OP_GT    = 4'h8,  // Signed X > O
        OP_ANDN  = 4'h9,  // X & ~O
        OP_XOR   = 4'hA,  // X ^ O
        OP_SUB   = 4'hB,  // X - O
        OP_XNOR  = 4'hC,  // X ^ ~O
        OP_SHR   = 4'hD,  // Logical X >> O
        OP_NE    = 4'hE,  // X != O
        OP_RSV15 = 4'hF   // Reserved
    } aluOp_t;

    // Phases of one instruction
    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        WRITE = 2'd3
    } seqState_t;

endpackage

`default_nettype wire

// File: rtl/cpuCore_defs.svh
`ifndef CPUCORE_DEFS_SVH
`define CPUCORE_DEFS_SVH

// Word address of the first fetch
`define RESET_VECTOR 32'h0000_1000

// Data path width
`define WORD_W 32

// Immediate field width
`define IMM_W 12

// Architectural registers, including zero and PC views
`define REG_COUNT 16

`endif
